//--- Makefile
# Verilator flow for the pipeline control unit

FILELIST = pipe_ctrl.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module pipe_ctrl -f $(FILELIST)

sim:
	verilator --binary --timing --assert --top-module pipe_ctrl_tb \
		-f $(FILELIST) -o sim_pipe_ctrl
	./obj_dir/sim_pipe_ctrl | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/pipe_ctrl_asserts.sv
// Pipeline control assertions

`timescale 1ns/100ps

module pipe_ctrl_asserts
    import pipe_ctrl_pkg::*;
(
    input logic            aclk,
    input logic            reset,
    input logic            mem_busy,
    input logic            exc_redirect,
    input stage_vec_t      stage_flush,
    input redirect_state_t rd_state     // redirect_seq state register
);

    // exception vector never taken while caches or tlb are busy
    exc_while_busy: assert property (@(posedge aclk) disable iff (reset)
        mem_busy |-> !exc_redirect)
        else $error("exc_redirect high while mem_busy is high");

    // frozen pipe must not lose instructions
    flush_while_busy: assert property (@(posedge aclk) disable iff (reset)
        mem_busy |-> (stage_flush == '0))
        else $error("stage_flush nonzero while mem_busy is high");

    // parked exception held until the back end is idle
    pending_held: assert property (@(posedge aclk) disable iff (reset)
        (rd_state == RD_PENDING && mem_busy) |=> (rd_state == RD_PENDING))
        else $error("redirect state left RD_PENDING while mem_busy was high");

endmodule

bind pipe_ctrl pipe_ctrl_asserts u_asserts (
    .aclk         (aclk),
    .reset        (reset),
    .mem_busy     (mem_busy),
    .exc_redirect (exc_redirect),
    .stage_flush  (stage_flush),
    .rd_state     (u_redirect_seq.state)
);

//--- dv/pipe_ctrl_tb.sv
// Pipeline control testbench

`timescale 1ns/100ps

module pipe_ctrl_tb
    import pipe_ctrl_pkg::*;
();

    logic       aclk;
    logic       reset;
    logic       flush_exception;
    logic       branch_failed;
    logic       imme_jump;
    logic       divmult_busy;
    logic       icache_busy;
    logic       dcache_busy;
    logic       i_tlb_stall;
    logic       d_tlb_stall;
    logic       mem_read;
    reg_num_t   mem_rt;
    reg_num_t   id_rs;
    reg_num_t   id_rt;
    stage_vec_t stage_wr;
    stage_vec_t stage_flush;
    dis_vec_t   dis_wr;
    logic       ireq_valid;
    logic       dreq_valid;

    // one entry per data row
    logic [8:0] ctl_q[$];          // exc, br, jmp, dm, ic, dc, it, dt, rd
    reg_num_t   mem_rt_q[$];
    reg_num_t   id_rs_q[$];
    reg_num_t   id_rt_q[$];
    logic [7:0] exp_wr_q[$];
    logic [7:0] exp_flush_q[$];
    logic [7:0] exp_dis_q[$];
    logic [7:0] exp_ireq_q[$];
    logic [7:0] exp_dreq_q[$];

    int mismatch_count = 0;
    int other_count    = 0;
    int row_count      = 0;
    int cur_row        = 0;
    bit rows_loaded    = 1'b0;

    pipe_ctrl uut (
        .aclk            (aclk),
        .reset           (reset),
        .flush_exception (flush_exception),
        .branch_failed   (branch_failed),
        .imme_jump       (imme_jump),
        .divmult_busy    (divmult_busy),
        .icache_busy     (icache_busy),
        .dcache_busy     (dcache_busy),
        .i_tlb_stall     (i_tlb_stall),
        .d_tlb_stall     (d_tlb_stall),
        .mem_read        (mem_read),
        .mem_rt          (mem_rt),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .stage_wr        (stage_wr),
        .stage_flush     (stage_flush),
        .dis_wr          (dis_wr),
        .ireq_valid      (ireq_valid),
        .dreq_valid      (dreq_valid)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;    // 8 ns period
    end

    task automatic load_rows();
        int          fd;
        int          code;
        int          fields;
        string       line;
        logic [31:0] col [17];
        fd = $fopen("dv/pipe_ctrl_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open test data file dv/pipe_ctrl_testdata.txt");
            other_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;   // comment or blank
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                             col[7], col[8], col[9], col[10], col[11], col[12],
                             col[13], col[14], col[15], col[16]);
            if (fields != 17) begin
                $display("Error: malformed line in test data file: %s", line);
                other_count++;
                continue;
            end
            ctl_q.push_back({col[0][0], col[1][0], col[2][0], col[3][0], col[4][0],
                             col[5][0], col[6][0], col[7][0], col[8][0]});
            mem_rt_q.push_back(col[9][4:0]);
            id_rs_q.push_back(col[10][4:0]);
            id_rt_q.push_back(col[11][4:0]);
            exp_wr_q.push_back(col[12][7:0]);
            exp_flush_q.push_back(col[13][7:0]);
            exp_dis_q.push_back(col[14][7:0]);
            exp_ireq_q.push_back(col[15][7:0]);
            exp_dreq_q.push_back(col[16][7:0]);
        end
        $fclose(fd);
        row_count = ctl_q.size();
        if (row_count == 0) begin
            $display("Error: test data file holds no rows");
            other_count++;
        end
    endtask

    task automatic idle_inputs();
        {flush_exception, branch_failed, imme_jump, divmult_busy, icache_busy,
         dcache_busy, i_tlb_stall, d_tlb_stall, mem_read} = 9'b0;
        mem_rt = '0;
        id_rs  = '0;
        id_rt  = '0;
    endtask

    task automatic apply_row(int idx);
        {flush_exception, branch_failed, imme_jump, divmult_busy, icache_busy,
         dcache_busy, i_tlb_stall, d_tlb_stall, mem_read} = ctl_q[idx];
        mem_rt = mem_rt_q[idx];
        id_rs  = id_rs_q[idx];
        id_rt  = id_rt_q[idx];
    endtask

    task automatic compare_value(string name, logic [7:0] actual, logic [7:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Fail at %0d ns, row %0d: %s expected %h actual %h",
                     $time, cur_row + 1, name, expected, actual);
        end
    endtask

    task automatic check_row(int idx);
        compare_value("stage_wr",    {1'b0, stage_wr},    exp_wr_q[idx]);
        compare_value("stage_flush", {1'b0, stage_flush}, exp_flush_q[idx]);
        compare_value("dis_wr",      {5'b0, dis_wr},      exp_dis_q[idx]);
        compare_value("ireq_valid",  {7'b0, ireq_valid},  exp_ireq_q[idx]);
        compare_value("dreq_valid",  {7'b0, dreq_valid},  exp_dreq_q[idx]);
    endtask

    task automatic print_summary();
        $display("Summary: %0d rows, %0d value mismatches, %0d other errors",
                 row_count, mismatch_count, other_count);
    endtask

    initial begin
        idle_inputs();
        reset = 1'b1;
        load_rows();
        rows_loaded = 1'b1;
        repeat (10) @(posedge aclk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < row_count; i++) begin
            cur_row = i;
            apply_row(i);           // 1 ns after the edge
            #6;
            check_row(i);           // just before the next edge
            @(posedge aclk);
            #1;
        end
        print_summary();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // bound is 8 ns per row plus slack for reset
    initial begin
        wait (rows_loaded);
        #(row_count * 8 + 200);
        $display("Error: simulation timed out before all rows were checked");
        other_count++;
        print_summary();
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- dv/pipe_ctrl_testdata.txt
// inputs: exc br jmp dm ic dc it dt rd mem_rt id_rs id_rt (all hex)
// expected: stage_wr stage_flush dis_wr ireq_valid dreq_valid
// idle after reset
0 0 0 0 0 0 0 0 0 00 00 00 7f 00 0 1 1
// load-use on rs, on rt, then register zero and mem_read low
0 0 0 0 0 0 0 0 1 05 05 03 78 08 0 0 1
0 0 0 0 0 0 0 0 1 0a 01 0a 78 08 0 0 1
0 0 0 0 0 0 0 0 1 00 00 00 7f 00 0 1 1
0 0 0 0 0 0 0 0 0 05 05 05 7f 00 0 1 1
// multiply/divide stall, alone and over load-use
0 0 0 1 0 0 0 0 0 00 00 00 70 10 0 0 0
0 0 0 1 0 0 0 0 1 05 05 03 70 10 0 0 0
// each cache and tlb busy input
0 0 0 0 1 0 0 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 1 0 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 0 1 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 0 0 1 0 00 00 00 00 00 7 0 0
// exception parked behind dcache busy, released on first idle row
1 0 0 0 0 1 0 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 1 0 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 1 0 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 1 0 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 0 0 0 0 00 00 00 7f 1e 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 7f 00 0 1 1
// branch, jump, then exception overriding both
0 1 0 0 0 0 0 0 0 00 00 00 7f 06 0 1 1
0 0 1 0 0 0 0 0 0 00 00 00 7f 02 0 1 1
1 1 1 0 0 0 0 0 0 00 00 00 7f 1e 0 0 0
0 1 0 0 1 0 0 0 0 00 00 00 00 00 7 0 0
// exception behind itlb refill, held exception ignored while pending
1 0 0 0 0 0 1 0 0 00 00 00 00 00 7 0 0
1 0 0 0 0 0 1 0 0 00 00 00 00 00 7 0 0
0 0 0 0 0 0 0 0 0 00 00 00 7f 1e 0 0 0
1 0 0 1 0 0 0 0 1 05 05 03 7f 1e 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 7f 00 0 1 1

//--- hdl/hazard_detect.sv
// Load-use and stall detection

`timescale 1ns/100ps

`include "pipe_ctrl_params.svh"

module hazard_detect
    import pipe_ctrl_pkg::*;
(
    input  logic     mem_read,      // load sitting in memory stage
    input  reg_num_t mem_rt,        // its destination
    input  reg_num_t id_rs,
    input  reg_num_t id_rt,
    input  logic     divmult_busy,
    input  logic     icache_busy,
    input  logic     dcache_busy,
    input  logic     i_tlb_stall,
    input  logic     d_tlb_stall,
    output logic     mem_busy,
    output logic     load_use,
    output logic     front_stall
);

    logic rt_nonzero;
    logic src_match;

    // $zero never carries a real dependency
    assign rt_nonzero = (mem_rt != {`REG_NUM_W{1'b0}});

    assign src_match = (mem_rt == id_rs) || (mem_rt == id_rt);

    // loaded value not ready for decode yet
    assign load_use = mem_read & rt_nonzero & src_match;

    // any cache or tlb transaction holds the whole back end
    assign mem_busy = icache_busy | dcache_busy | i_tlb_stall | d_tlb_stall;

    // front end must wait for either condition
    assign front_stall = load_use | divmult_busy;

endmodule

//--- hdl/pipe_ctrl.sv
// Pipeline control unit top level

`timescale 1ns/100ps

`include "pipe_ctrl_params.svh"

module pipe_ctrl
    import pipe_ctrl_pkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  logic       flush_exception,
    input  logic       branch_failed,
    input  logic       imme_jump,
    input  logic       divmult_busy,
    input  logic       icache_busy,
    input  logic       dcache_busy,
    input  logic       i_tlb_stall,
    input  logic       d_tlb_stall,
    input  logic       mem_read,
    input  reg_num_t   mem_rt,
    input  reg_num_t   id_rs,
    input  reg_num_t   id_rt,
    output stage_vec_t stage_wr,
    output stage_vec_t stage_flush,
    output dis_vec_t   dis_wr,
    output logic       ireq_valid,
    output logic       dreq_valid
);

    logic mem_busy;       // back end held by cache/tlb
    logic load_use;
    logic front_stall;
    logic exc_redirect;
    logic br_redirect;
    logic jmp_redirect;

    hazard_detect u_hazard_detect (
        .mem_read     (mem_read),
        .mem_rt       (mem_rt),
        .id_rs        (id_rs),
        .id_rt        (id_rt),
        .divmult_busy (divmult_busy),
        .icache_busy  (icache_busy),
        .dcache_busy  (dcache_busy),
        .i_tlb_stall  (i_tlb_stall),
        .d_tlb_stall  (d_tlb_stall),
        .mem_busy     (mem_busy),
        .load_use     (load_use),
        .front_stall  (front_stall)
    );

    redirect_seq u_redirect_seq (
        .aclk            (aclk),
        .reset           (reset),
        .flush_exception (flush_exception),
        .branch_failed   (branch_failed),
        .imme_jump       (imme_jump),
        .mem_busy        (mem_busy),
        .exc_redirect    (exc_redirect),
        .br_redirect     (br_redirect),
        .jmp_redirect    (jmp_redirect)
    );

    stage_enable u_stage_enable (
        .mem_busy     (mem_busy),
        .load_use     (load_use),
        .front_stall  (front_stall),
        .divmult_busy (divmult_busy),
        .exc_redirect (exc_redirect),
        .br_redirect  (br_redirect),
        .jmp_redirect (jmp_redirect),
        .stage_wr     (stage_wr),
        .stage_flush  (stage_flush),
        .dis_wr       (dis_wr),
        .ireq_valid   (ireq_valid),
        .dreq_valid   (dreq_valid)
    );

endmodule

//--- hdl/pipe_ctrl_pkg.sv
// Pipeline control types

`include "pipe_ctrl_params.svh"

package pipe_ctrl_pkg;

    // one bit per stage indexed by the STG_* macros
    typedef logic [`PIPE_STAGES-1:0] stage_vec_t;

    // architectural register number
    typedef logic [`REG_NUM_W-1:0] reg_num_t;

    // side-effect disables for the back end
    // bit 0 execute, bit 1 memory, bit 2 write-back
    typedef logic [2:0] dis_vec_t;

    // exception redirect tracking
    typedef enum logic [1:0] {
        RD_IDLE    = 2'd0,  // nothing held
        RD_PENDING = 2'd1   // exception waiting for caches/tlb
    } redirect_state_t;

endpackage

//--- hdl/redirect_seq.sv
// Exception, branch and jump redirect sequencing

`timescale 1ns/100ps

`include "pipe_ctrl_params.svh"

module redirect_seq
    import pipe_ctrl_pkg::*;
(
    input  logic aclk,
    input  logic reset,
    input  logic flush_exception,   // exception raised at memory
    input  logic branch_failed,     // mispredict from execute
    input  logic imme_jump,         // j/jal in decode
    input  logic mem_busy,
    output logic exc_redirect,      // one-cycle pulse
    output logic br_redirect,
    output logic jmp_redirect
);

    redirect_state_t state;
    redirect_state_t state_nxt;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // an exception seen while the memory side is busy is parked
    // in RD_PENDING and released on the first idle cycle
    always_comb begin
        state_nxt    = state;
        exc_redirect = 1'b0;
        case (state)
            RD_IDLE: begin
                if (flush_exception) begin
                    if (mem_busy) begin
                        state_nxt = RD_PENDING;  // wait for caches
                    end else begin
                        exc_redirect = 1'b1;     // take it now
                    end
                end
            end
            RD_PENDING: begin
                if (!mem_busy) begin
                    exc_redirect = 1'b1;
                    state_nxt    = RD_IDLE;
                end
            end
            default: begin
                state_nxt = RD_IDLE;
            end
        endcase
    end

    // front-end redirects only while the back end can take them
    assign br_redirect  = branch_failed & ~mem_busy;
    assign jmp_redirect = imme_jump & ~mem_busy;

endmodule

//--- hdl/stage_enable.sv
// Per-stage write enable and flush generation

`timescale 1ns/100ps

`include "pipe_ctrl_params.svh"

module stage_enable
    import pipe_ctrl_pkg::*;
(
    input  logic       mem_busy,
    input  logic       load_use,
    input  logic       front_stall,
    input  logic       divmult_busy,
    input  logic       exc_redirect,
    input  logic       br_redirect,
    input  logic       jmp_redirect,
    output stage_vec_t stage_wr,
    output stage_vec_t stage_flush,
    output dis_vec_t   dis_wr,
    output logic       ireq_valid,
    output logic       dreq_valid
);

    // first matching condition wins
    always_comb begin
        stage_wr    = '1;
        stage_flush = '0;
        dis_wr      = '0;
        if (mem_busy) begin
            stage_wr = '0;            // freeze everything
            dis_wr   = '1;            // block cp0/rf side effects
        end else if (exc_redirect) begin
            stage_flush[`STG_IF]  = 1'b1;
            stage_flush[`STG_ID]  = 1'b1;
            stage_flush[`STG_EXE] = 1'b1;
            stage_flush[`STG_MEM] = 1'b1;
        end else if (front_stall) begin
            if (divmult_busy) begin
                // hold up to execute, bubble into memory
                stage_wr[`STG_PREIF] = 1'b0;
                stage_wr[`STG_IF]    = 1'b0;
                stage_wr[`STG_ID]    = 1'b0;
                stage_wr[`STG_EXE]   = 1'b0;
                stage_flush[`STG_MEM] = 1'b1;
            end else if (load_use) begin
                // hold up to decode, bubble into execute
                stage_wr[`STG_PREIF] = 1'b0;
                stage_wr[`STG_IF]    = 1'b0;
                stage_wr[`STG_ID]    = 1'b0;
                stage_flush[`STG_EXE] = 1'b1;
            end
        end else if (br_redirect) begin
            stage_flush[`STG_IF] = 1'b1;   // wrong-path fetch and decode
            stage_flush[`STG_ID] = 1'b1;
        end else if (jmp_redirect) begin
            stage_flush[`STG_IF] = 1'b1;   // delay slot stays in decode
        end
    end

    // fetch only when pc advances and no exception vector is pending
    assign ireq_valid = stage_wr[`STG_PREIF] & ~exc_redirect;

    // data access only for a live instruction entering memory
    assign dreq_valid = stage_wr[`STG_MEM] & ~stage_flush[`STG_MEM];

endmodule

//--- include/pipe_ctrl_params.svh
// Pipeline control widths and stage indices

`ifndef PIPE_CTRL_PARAMS_SVH
`define PIPE_CTRL_PARAMS_SVH

// seven stages from pre-fetch to write-back
`define PIPE_STAGES 7

// bit positions inside a stage vector
`define STG_PREIF 0
`define STG_IF    1
`define STG_ID    2
`define STG_EXE   3
`define STG_MEM   4
`define STG_MEM2  5
`define STG_WB    6

// mips register file has 32 entries
`define REG_NUM_W 5

`endif

//--- pipe_ctrl.f
+incdir+include
hdl/pipe_ctrl_pkg.sv
hdl/hazard_detect.sv
hdl/redirect_seq.sv
hdl/stage_enable.sv
hdl/pipe_ctrl.sv
dv/pipe_ctrl_asserts.sv
dv/pipe_ctrl_tb.sv
